// ==== compile.f ====
verilog/rom_map_pkg.sv
verilog/cen_gen.sv
verilog/download_map.sv
verilog/rom_slot.sv
verilog/sdram_arbiter.sv
verilog/game_rom_top.sv
tests/game_rom_assertions.sv
tests/tb_game_rom.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the game ROM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_game_rom -f compile.f \
    -o sim_game_rom > build.log 2>&1 \
    && ./obj_dir/sim_game_rom > sim.log 2>&1 \
    || echo "TEST RESULT: FAIL" >> sim.log

cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

// ==== tests/tb_game_rom.sv ====
// ####################
// Game ROM testbench
// Clock, reset and SDRAM model
// Reference functions and compare tasks
// Clock enable, download and slot read tests
// ####################

`timescale 1ns/1ps
`default_nettype none

module tb_game_rom;

    import rom_map_pkg::*;

    localparam int n_reads    = 6;
    localparam int n_trans    = 9 + 2 * 4 * n_reads + 4 + 1 + 4; // Includes reset and enables
    localparam int max_cycles = n_trans * 40;

    logic clk = 1'b0;
    logic rst_n, downloading, ioctl_wr, prog_we, prom_we, vblank;
    ioctl_addr_t ioctl_addr;
    logic [7:0]  ioctl_data, prog_data;
    sdram_addr_t prog_addr, sdram_addr;
    prog_mask_t  prog_mask;
    logic        char_cs, scr_cs, main_cs, obj_cs;
    logic [15:0] char_addr;
    logic [16:0] scr_addr;
    logic [17:0] main_addr;
    logic [18:0] obj_addr;
    logic [7:0]  char_data, main_data;
    logic [15:0] scr_data, obj_data;
    logic        char_ok, scr_ok, main_ok, obj_ok;
    logic        sdram_req, sdram_ack, data_rdy, pxl2_cen, pxl_cen;
    sdram_word_t data_read;
    int          cycles = 0;
    int          read_count = 0;   // SDRAM reads served by the model
    int          stim_seed = 65005;
    int          model_seed = 65005;

    game_rom_top i_game_rom_top (.*);

    // One fetch in flight, so no new request while data returns
    bind sdram_arbiter game_rom_assertions i_arb_assertions (.clk(clk), .rst_n(rst_n),
        .hold_off(downloading), .req(sdram_req), .ack(sdram_ack),
        .strobe_a(sdram_req), .strobe_b(data_rdy));
    bind download_map game_rom_assertions i_dl_assertions (.clk(clk), .rst_n(rst_n),
        .hold_off(!downloading), .req(prog_we), .ack(sdram_ack),
        .strobe_a(prog_we), .strobe_b(prom_we));

    always #5 clk = ~clk;

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) fail_now("Timeout: the run went past its cycle limit");
    end

    task automatic check_word(string name, sdram_addr_t got, sdram_addr_t exp);
        if (got !== exp) fail_now($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) fail_now($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_half(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) fail_now($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) fail_now($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    // Scrambled halfword content of the SDRAM
    function automatic logic [15:0] ref_word(sdram_addr_t a);
        logic [15:0] h;
        h = a[15:0] ^ {a[21:16], a[21:12]} ^ 16'h5A3C;
        return {h[10:0], h[15:11]} + 16'h1357;
    endfunction

    function automatic sdram_addr_t ref_prog_addr(ioctl_addr_t a);
        if (a >= 25'h190000) return sdram_addr_t'(a - 25'h190000);
        if (a >= 25'h0D0000) return 22'h080000 + sdram_addr_t'((a - 25'h0D0000) >> 1);
        if (a >= 25'h090000) return 22'h060000 + sdram_addr_t'((a - 25'h090000) >> 1);
        return sdram_addr_t'(a >> 1);
    endfunction

    // Slots 0 to 3 are char, scr, main, obj
    function automatic logic [15:0] ref_slot_data(int s, logic [18:0] a);
        sdram_addr_t off;
        sdram_addr_t base;
        logic [15:0] h;
        off = (s == 0) ? 22'h040000 : (s == 1) ? 22'h060000 : (s == 2) ? 22'h0 : 22'h080000;
        if (s == 1 || s == 3) begin
            base = off + sdram_addr_t'({a >> 1, 1'b0});
            return ref_word(base + sdram_addr_t'(a[0]));
        end
        base = off + sdram_addr_t'({a >> 2, 1'b0});
        h = ref_word(base + sdram_addr_t'(a[1]));
        return a[0] ? {8'h00, h[15:8]} : {8'h00, h[7:0]};
    endfunction

    function automatic logic [18:0] slot_mask(int s);
        return (19'd1 << (16 + s)) - 19'd1;  // aw is 16 + slot index
    endfunction

    function automatic logic slot_ok(int s);
        return (s == 0) ? char_ok : (s == 1) ? scr_ok : (s == 2) ? main_ok : obj_ok;
    endfunction

    task automatic drive_slot(int s, logic c, logic [18:0] a);
        case (s)
            0: begin
                char_cs   <= c;
                char_addr <= a[15:0];
            end
            1: begin
                scr_cs   <= c;
                scr_addr <= a[16:0];
            end
            2: begin
                main_cs   <= c;
                main_addr <= a[17:0];
            end
            default: begin
                obj_cs   <= c;
                obj_addr <= a;
            end
        endcase
    endtask

    task automatic check_slot(int s, logic [18:0] a);
        logic [15:0] exp;
        exp = ref_slot_data(s, a);
        case (s)
            0: check_byte("char_data", char_data, exp[7:0]);
            1: check_half("scr_data", scr_data, exp);
            2: check_byte("main_data", main_data, exp[7:0]);
            default: check_half("obj_data", obj_data, exp);
        endcase
    endtask

    task automatic read_slot(int s, logic [18:0] a);
        @(posedge clk);
        drive_slot(s, 1'b1, a);
        repeat (2) @(posedge clk);   // Skip the ok of the old address
        while (!slot_ok(s)) @(posedge clk);
        check_slot(s, a);
    endtask

    task automatic dl_write(ioctl_addr_t a);
        logic [31:0] r;
        logic [7:0]  d;
        r = $random(stim_seed);
        d = r[7:0];
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(posedge clk);
        check_word("prog_addr", prog_addr, ref_prog_addr(a));
        if (a >= 25'h190000) begin
            check_bit("prom_we", prom_we, 1'b1);
            check_bit("prog_we", prog_we, 1'b0);
            @(posedge clk);
            check_bit("prom_we", prom_we, 1'b0);
        end else begin
            check_byte("prog_data", prog_data, d);
            check_byte("prog_mask", {6'd0, prog_mask}, a[0] ? 8'h01 : 8'h02);
            check_bit("prom_we", prom_we, 1'b0);
            check_bit("prog_we", prog_we, 1'b1);
            while (!sdram_ack) begin
                @(posedge clk);
                check_bit("prog_we", prog_we, 1'b1);
            end
            @(posedge clk);
            check_bit("prog_we", prog_we, 1'b0);
        end
    endtask

    // SDRAM model for download writes and slot reads
    initial begin : sdram_model
        sdram_addr_t a;
        logic        rd;
        logic [31:0] r;
        forever begin
            @(posedge clk);
            if (rst_n && (sdram_req || prog_we)) begin
                rd = sdram_req;
                a  = sdram_addr;
                r  = $random(model_seed);
                repeat (int'(r[1:0])) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                if (rd) begin
                    read_count++;
                    repeat (int'(r[3:2])) @(posedge clk);
                    data_rdy  <= 1'b1;
                    data_read <= {ref_word(a + 22'd1), ref_word(a)};
                    @(posedge clk);
                    data_rdy <= 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [18:0] a;
        logic [18:0] addrs[4];
        int          cnt;
        rst_n       <= 1'b0;
        downloading <= 1'b0;
        ioctl_wr    <= 1'b0;
        ioctl_addr  <= '0;
        ioctl_data  <= '0;
        vblank      <= 1'b0;
        sdram_ack   <= 1'b0;
        data_rdy    <= 1'b0;
        data_read   <= '0;
        for (int s = 0; s < 4; s++) drive_slot(s, 1'b0, 19'd0);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int k = 1; k <= 64; k++) begin
            @(posedge clk);
            check_bit("pxl2_cen", pxl2_cen, k % 4 == 0);
            check_bit("pxl_cen", pxl_cen, k % 8 == 0);
        end
        @(posedge clk);
        downloading <= 1'b1;
        dl_write(25'h000123);
        dl_write(25'h000124);
        dl_write(25'h090005);
        dl_write(25'h0CFFFE);
        dl_write(25'h0D0001);
        dl_write(25'h18FFFF);
        dl_write(25'h190000);
        dl_write(25'h1900A7);
        @(posedge clk);
        downloading <= 1'b0;
        // A write outside the download is dropped
        @(posedge clk);
        ioctl_addr <= 25'h000200;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            check_bit("prog_we", prog_we, 1'b0);
        end
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < n_reads; i++) begin
                r = $random(stim_seed);
                a = r[18:0] & slot_mask(s);
                read_slot(s, a);
                cnt = read_count;
                read_slot(s, a ^ 19'd1);   // Same cached pair
                check_bit("sdram_req", sdram_req, 1'b0);
                check_bit("sdram_req", read_count != cnt, 1'b0);
            end
            @(posedge clk);
            drive_slot(s, 1'b0, 19'd0);
        end
        // All slots at once with tiles held off by vblank
        @(posedge clk);
        vblank <= 1'b1;
        for (int s = 0; s < 4; s++) begin
            r = $random(stim_seed);
            addrs[s] = r[18:0] & slot_mask(s);
            drive_slot(s, 1'b1, addrs[s]);
        end
        repeat (2) @(posedge clk);
        while (!(main_ok && obj_ok)) begin
            check_bit("char_ok", char_ok, 1'b0);
            check_bit("scr_ok", scr_ok, 1'b0);
            @(posedge clk);
        end
        vblank <= 1'b0;
        repeat (2) @(posedge clk);
        while (!(char_ok && scr_ok)) @(posedge clk);
        for (int s = 0; s < 4; s++) check_slot(s, addrs[s]);
        // Main miss held off while downloading
        @(posedge clk);
        a = (addrs[2] ^ 19'h00100) & slot_mask(2);
        downloading <= 1'b1;
        drive_slot(2, 1'b1, a);
        repeat (20) begin
            @(posedge clk);
            check_bit("sdram_req", sdram_req, 1'b0);
        end
        downloading <= 1'b0;
        repeat (2) @(posedge clk);
        while (!main_ok) @(posedge clk);
        check_slot(2, a);
        @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/game_rom_assertions.sv ====
// ####################
// Bound assertions
// Request held until acknowledge
// No request raised while held off
// Two strobes never high together
// ####################

`timescale 1ns/1ps
`default_nettype none

module game_rom_assertions (
    input wire clk,
    input wire rst_n,
    input wire hold_off,
    input wire req,
    input wire ack,
    input wire strobe_a,
    input wire strobe_b
);

    // The requester waits for the acknowledge
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req && !ack |=> req)
        else $error("request dropped before its acknowledge");

    a_no_req_held_off: assert property (@(posedge clk) disable iff (!rst_n)
        hold_off |=> !$rose(req))
        else $error("request raised while held off");

    a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(strobe_a && strobe_b))
        else $error("two exclusive strobes high in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/game_rom_top.sv ====
// ####################
// Game ROM top level
// Clock enables, download mapper
// Four ROM slots sharing one SDRAM port
// ####################

`timescale 1ns/1ps
`default_nettype none

module game_rom_top (
    input  wire                           clk,
    input  wire                           rst_n,
    // Download stream
    input  wire                           downloading,
    input  wire rom_map_pkg::ioctl_addr_t ioctl_addr,
    input  wire [7:0]                     ioctl_data,
    input  wire                           ioctl_wr,
    output rom_map_pkg::sdram_addr_t      prog_addr,
    output logic [7:0]                    prog_data,
    output rom_map_pkg::prog_mask_t       prog_mask,
    output logic                          prog_we,
    output logic                          prom_we,
    // ROM slots
    input  wire                           char_cs,
    input  wire [15:0]                    char_addr,
    output logic [7:0]                    char_data,
    output logic                          char_ok,
    input  wire                           scr_cs,
    input  wire [16:0]                    scr_addr,
    output logic [15:0]                   scr_data,
    output logic                          scr_ok,
    input  wire                           main_cs,
    input  wire [17:0]                    main_addr,
    output logic [7:0]                    main_data,
    output logic                          main_ok,
    input  wire                           obj_cs,
    input  wire [18:0]                    obj_addr,
    output logic [15:0]                   obj_data,
    output logic                          obj_ok,
    input  wire                           vblank,
    // SDRAM
    output logic                          sdram_req,
    output rom_map_pkg::sdram_addr_t      sdram_addr,
    input  wire                           sdram_ack,
    input  wire                           data_rdy,
    input  wire rom_map_pkg::sdram_word_t data_read,
    output logic                          pxl2_cen,
    output logic                          pxl_cen
);

    import rom_map_pkg::*;

    logic [3:0]  miss;          // main, char, scr, obj from bit 0
    logic [3:0]  fill;
    sdram_word_t fill_data;
    sdram_addr_t fetch_addr_main;
    sdram_addr_t fetch_addr_char;
    sdram_addr_t fetch_addr_scr;
    sdram_addr_t fetch_addr_obj;
    logic        char_cs_vis;
    logic        scr_cs_vis;

    // Tile fetches only happen during active video
    assign char_cs_vis = char_cs && !vblank;
    assign scr_cs_vis  = scr_cs && !vblank;

    cen_gen i_cen_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen)
    );

    download_map i_download_map (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    rom_slot #(.aw(16), .dw(8), .offset(char_offset)) i_char_slot (
        .clk (clk), .rst_n (rst_n), .cs (char_cs_vis), .addr (char_addr),
        .data (char_data), .ok (char_ok), .miss (miss[1]),
        .fetch_addr (fetch_addr_char), .fill (fill[1]), .fill_data (fill_data)
    );

    rom_slot #(.aw(17), .dw(16), .offset(scr_sdram)) i_scr_slot (
        .clk (clk), .rst_n (rst_n), .cs (scr_cs_vis), .addr (scr_addr),
        .data (scr_data), .ok (scr_ok), .miss (miss[2]),
        .fetch_addr (fetch_addr_scr), .fill (fill[2]), .fill_data (fill_data)
    );

    rom_slot #(.aw(18), .dw(8), .offset(main_offset)) i_main_slot (
        .clk (clk), .rst_n (rst_n), .cs (main_cs), .addr (main_addr),
        .data (main_data), .ok (main_ok), .miss (miss[0]),
        .fetch_addr (fetch_addr_main), .fill (fill[0]), .fill_data (fill_data)
    );

    rom_slot #(.aw(19), .dw(16), .offset(obj_sdram)) i_obj_slot (
        .clk (clk), .rst_n (rst_n), .cs (obj_cs), .addr (obj_addr),
        .data (obj_data), .ok (obj_ok), .miss (miss[3]),
        .fetch_addr (fetch_addr_obj), .fill (fill[3]), .fill_data (fill_data)
    );

    sdram_arbiter i_sdram_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .downloading     (downloading),
        .miss            (miss),
        .fetch_addr_main (fetch_addr_main),
        .fetch_addr_char (fetch_addr_char),
        .fetch_addr_scr  (fetch_addr_scr),
        .fetch_addr_obj  (fetch_addr_obj),
        .fill            (fill),
        .fill_data       (fill_data),
        .sdram_req       (sdram_req),
        .sdram_addr      (sdram_addr),
        .sdram_ack       (sdram_ack),
        .data_rdy        (data_rdy),
        .data_read       (data_read)
    );

endmodule

`default_nettype wire

// ==== verilog/sdram_arbiter.sv ====
// ####################
// SDRAM read arbiter
// Fixed priority main, char, scr, obj
// One fetch in flight, fill pulse on data_rdy
// ####################

`timescale 1ns/1ps
`default_nettype none

module sdram_arbiter (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           downloading,
    input  wire [3:0]                     miss,
    input  wire rom_map_pkg::sdram_addr_t fetch_addr_main,
    input  wire rom_map_pkg::sdram_addr_t fetch_addr_char,
    input  wire rom_map_pkg::sdram_addr_t fetch_addr_scr,
    input  wire rom_map_pkg::sdram_addr_t fetch_addr_obj,
    output logic [3:0]                    fill,
    output rom_map_pkg::sdram_word_t      fill_data,
    output logic                          sdram_req,
    output rom_map_pkg::sdram_addr_t      sdram_addr,
    input  wire                           sdram_ack,
    input  wire                           data_rdy,
    input  wire rom_map_pkg::sdram_word_t data_read
);

    import rom_map_pkg::*;

    // Bit positions in miss and fill, highest priority first
    localparam slot_sel_t slot_main = 2'd0;
    localparam slot_sel_t slot_char = 2'd1;
    localparam slot_sel_t slot_scr  = 2'd2;
    localparam slot_sel_t slot_obj  = 2'd3;

    arb_state_t  state;
    slot_sel_t   pick;
    slot_sel_t   sel;        // Slot being served
    sdram_addr_t pick_addr;

    always_comb begin
        if (miss[slot_main]) begin
            pick = slot_main;
        end else if (miss[slot_char]) begin
            pick = slot_char;
        end else if (miss[slot_scr]) begin
            pick = slot_scr;
        end else begin
            pick = slot_obj;
        end
    end

    always_comb begin
        case (pick)
            slot_main: pick_addr = fetch_addr_main;
            slot_char: pick_addr = fetch_addr_char;
            slot_scr:  pick_addr = fetch_addr_scr;
            default:   pick_addr = fetch_addr_obj;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= arb_idle;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    // Download owns the SDRAM port
                    if (!downloading && |miss) begin
                        sdram_req <= 1'b1;
                        state     <= arb_wait_ack;
                    end
                end
                arb_wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= arb_wait_data;
                    end
                end
                arb_wait_data: begin
                    if (data_rdy) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // Address and index held stable for the whole fetch
    always_ff @(posedge clk) begin
        if (state == arb_idle) begin
            sel        <= pick;
            sdram_addr <= pick_addr;
        end
    end

    assign fill      = (state == arb_wait_data && data_rdy) ? (4'b0001 << sel) : 4'b0000;
    assign fill_data = data_read;   // Slots capture it with fill

endmodule

`default_nettype wire

// ==== verilog/rom_slot.sv ====
// ####################
// ROM read slot
// One cached 32-bit SDRAM word
// Miss request and byte or halfword select
// ####################

`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter int                       aw     = 16,
    parameter int                       dw     = 8,
    parameter rom_map_pkg::sdram_addr_t offset = '0
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           cs,
    input  wire [aw-1:0]                  addr,
    output logic [dw-1:0]                 data,
    output logic                          ok,
    output logic                          miss,
    output rom_map_pkg::sdram_addr_t      fetch_addr,
    input  wire                           fill,
    input  wire rom_map_pkg::sdram_word_t fill_data
);

    import rom_map_pkg::*;

    // Address bits that pick the lane inside the cached pair
    localparam int sub_bits = (dw == 16) ? 1 : 2;

    logic [aw-1:0]       pair;
    logic [sub_bits-1:0] lane;
    sdram_addr_t         cached_addr;  // Even word address of the pair
    sdram_word_t         cached_word;
    sdram_word_t         src_word;
    logic                valid;
    logic                hit;

    assign pair       = addr >> sub_bits;
    assign lane       = addr[sub_bits-1:0];
    assign fetch_addr = offset + sdram_addr_t'({pair, 1'b0});

    assign hit  = valid && (cached_addr == fetch_addr);
    assign miss = cs && !hit;

    // Fresh data bypasses the cache in the fill cycle
    assign src_word = fill ? fill_data : cached_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            if (fill) begin
                valid <= 1'b1;
            end
            ok <= cs && (hit || fill);   // Drops once addr leaves the pair
        end
    end

    // Fill assumes addr held still while the fetch was out
    always_ff @(posedge clk) begin
        if (fill) begin
            cached_addr <= fetch_addr;
            cached_word <= fill_data;
        end
        data <= src_word[lane*dw +: dw]; // Low lane first
    end

endmodule

`default_nettype wire

// ==== verilog/download_map.sv ====
// ####################
// Download mapper
// Byte address to SDRAM word address
// Scroll and object relocation
// Byte lane mask, prog_we and prom_we
// ####################

`timescale 1ns/1ps
`default_nettype none

module download_map (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      downloading,
    input  wire rom_map_pkg::ioctl_addr_t ioctl_addr,
    input  wire [7:0]                ioctl_data,
    input  wire                      ioctl_wr,
    input  wire                      sdram_ack,
    output rom_map_pkg::sdram_addr_t prog_addr,
    output logic [7:0]               prog_data,
    output rom_map_pkg::prog_mask_t  prog_mask,
    output logic                     prog_we,
    output logic                     prom_we
);

    import rom_map_pkg::*;

    ioctl_addr_t offs;      // Byte offset into the matched region
    sdram_addr_t next_addr;
    logic        is_prom;
    logic        wr_en;

    assign wr_en = ioctl_wr && downloading;

    always_comb begin
        offs      = '0;
        is_prom   = 1'b0;
        next_addr = sdram_addr_t'(ioctl_addr >> 1);
        if (ioctl_addr >= prom_start) begin
            // PROM gets byte addressing
            is_prom   = 1'b1;
            offs      = ioctl_addr - prom_start;
            next_addr = sdram_addr_t'(offs);
        end else if (ioctl_addr >= objwz_start && ioctl_addr < obj_end) begin
            offs      = ioctl_addr - objwz_start;
            next_addr = obj_sdram + sdram_addr_t'(offs >> 1);
        end else if (ioctl_addr >= scrzw_start && ioctl_addr < objwz_start) begin
            offs      = ioctl_addr - scrzw_start;
            next_addr = scr_sdram + sdram_addr_t'(offs >> 1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;                // Single cycle pulse
            if (wr_en) begin
                prog_we <= !is_prom;
                prom_we <= is_prom;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;            // SDRAM took the byte
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog_addr <= next_addr;
            prog_data <= ioctl_data;
            prog_mask <= {~ioctl_addr[0], ioctl_addr[0]}; // Even byte writes lane 0
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cen_gen.sv ====
// ####################
// Pixel clock enables
// pxl2_cen one cycle in four
// pxl_cen one cycle in eight
// ####################

`timescale 1ns/1ps
`default_nettype none

module cen_gen (
    input  wire  clk,
    input  wire  rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    // Enables are registered one count early so that they line up
    // with counts 3 and 7 of the free running divider
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= 3'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 3'd1;
            pxl2_cen <= (cnt[1:0] == 2'd2);
            pxl_cen  <= (cnt == 3'd6);    // Also a pxl2_cen count
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rom_map_pkg.sv ====
// ####################
// ROM map package
// Address, data and mask types
// Download regions and relocated SDRAM bases
// Fixed slot offsets and arbiter states
// ####################

`default_nettype none

package rom_map_pkg;

    // SDRAM address in 16-bit words
    typedef logic [21:0] sdram_addr_t;

    // Byte address of the download stream
    typedef logic [24:0] ioctl_addr_t;

    // Even halfword in the low half, next halfword in the high half
    typedef logic [31:0] sdram_word_t;

    // Active low, a cleared bit enables that byte lane
    typedef logic [1:0]  prog_mask_t;

    typedef logic [1:0]  slot_sel_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_wait_ack,
        arb_wait_data
    } arb_state_t;

    // Download regions, byte addresses
    localparam ioctl_addr_t scrzw_start = 25'h009_0000;
    localparam ioctl_addr_t objwz_start = 25'h00D_0000;
    localparam ioctl_addr_t obj_end     = 25'h019_0000;
    localparam ioctl_addr_t prom_start  = 25'h019_0000; // PROM goes to BRAM, not SDRAM

    // Relocated bases, word addresses
    localparam sdram_addr_t scr_sdram   = 22'h06_0000;
    localparam sdram_addr_t obj_sdram   = 22'h08_0000;

    // Slots that read data where it was downloaded
    localparam sdram_addr_t char_offset = 22'h04_0000; // Byte 0x80000 of the stream
    localparam sdram_addr_t main_offset = 22'h00_0000;

endpackage

`default_nettype wire
